/* common/cpu_pkg.sv */
// Widths and encodings for the execute back end. Data memory is 256 words and word addressed
package cpu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int DATA_W     = 16;              // Data and PC width
  localparam int REG_W      = 4;               // Register index
  localparam int CALL_W     = 12;              // Call target field
  localparam int DMEM_AW    = 8;               // Word address
  localparam int DMEM_DEPTH = 1 << DMEM_AW;    // 256 words

  localparam logic [DMEM_AW-1:0] STACK_TOP = 8'hFF;  // First push lands here

  // Flag bit positions
  localparam int FLAG_Z = 2;
  localparam int FLAG_N = 1;
  localparam int FLAG_V = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_LHI
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NE, BR_EQ, BR_GT, BR_LT, BR_GE, BR_LE, BR_OVF, BR_ALWAYS
  } br_cond_e;

  typedef enum logic [2:0] {
    CL_ALU, CL_LOAD, CL_STORE, CL_BRANCH, CL_CALL, CL_RET
  } op_class_e;

endpackage

/* common/mem_if.sv */
// One requester port on the shared data memory. Request holds until granted and read data follows one cycle later
`timescale 1ns/1ns
interface mem_if import cpu_pkg::*; ();

  logic               req;    // Access wanted
  logic               we;     // Write when set
  logic [DMEM_AW-1:0] addr;   // Word address
  logic [DATA_W-1:0]  wdata;  // Store data
  logic               gnt;    // Access happens this cycle
  logic [DATA_W-1:0]  rdata;  // Valid the cycle after a read grant

  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rdata
  );

endinterface

/* ex_unit/alu.sv */
// Combinational ALU. Shift distance is 4 bits and V is only set by add and subtract
`timescale 1ns/1ns
module alu import cpu_pkg::*; (
  input  alu_op_e            alu_op,         // Operation select
  input  logic [DATA_W-1:0]  a,              // First operand
  input  logic [DATA_W-1:0]  b,              // Second operand
  input  logic [3:0]         shift,          // Shift distance
  input  logic [7:0]         load_half_imm,  // New high byte for LHI
  output logic [DATA_W-1:0]  result,
  output logic [2:0]         new_flags
);

  logic ovf;  // Signed overflow of add or sub

  always_comb begin
    result = '0;
    ovf    = 1'b0;
    case (alu_op)
      OP_ADD: begin
        result = a + b;
        ovf    = (a[DATA_W-1] == b[DATA_W-1]) && (result[DATA_W-1] != a[DATA_W-1]);
      end
      OP_SUB: begin
        result = a - b;
        ovf    = (a[DATA_W-1] != b[DATA_W-1]) && (result[DATA_W-1] != a[DATA_W-1]);
      end
      OP_AND: result = a & b;
      OP_OR:  result = a | b;
      OP_XOR: result = a ^ b;
      OP_SLL: result = a << shift;            // Zero fill
      OP_SRL: result = a >> shift;            // Logical, no sign fill
      OP_LHI: result = {load_half_imm, a[7:0]};  // Low byte kept
      default: result = a;
    endcase
  end

  always_comb begin
    new_flags         = '0;
    new_flags[FLAG_Z] = (result == '0);
    new_flags[FLAG_N] = result[DATA_W-1];
    new_flags[FLAG_V] = ovf;
  end

endmodule

/* ex_unit/pc_update.sv */
// Branch condition check on stored flags. A failed check puts the zero-extended call target on target
`timescale 1ns/1ns
module pc_update import cpu_pkg::*; (
  input  logic [DATA_W-1:0]  pc_in,        // PC of the branch
  input  logic [DATA_W-1:0]  sign_ext,     // Branch offset
  input  logic [2:0]         flags,        // Flags the check runs against
  input  br_cond_e           branch_cond,
  input  logic [CALL_W-1:0]  call_target,  // Absolute call address
  output logic               taken,
  output logic [DATA_W-1:0]  target
);

  logic z;
  logic n;
  logic v;

  assign z = flags[FLAG_Z];
  assign n = flags[FLAG_N];
  assign v = flags[FLAG_V];

  always_comb begin
    case (branch_cond)
      BR_NE:     taken = !z;
      BR_EQ:     taken = z;
      BR_GT:     taken = !z && !n;  // Strictly positive
      BR_LT:     taken = n;
      BR_GE:     taken = !n;
      BR_LE:     taken = z || n;
      BR_OVF:    taken = v;
      BR_ALWAYS: taken = 1'b1;
      default:   taken = 1'b0;
    endcase
  end

  // Relative target when taken, call slot otherwise
  assign target = taken ? (pc_in + sign_ext)
                        : {{(DATA_W-CALL_W){1'b0}}, call_target};

endmodule

/* ex_unit/ex_unit.sv */
// Execute stage. Holds issue while the needed peer is busy. ALU wins writeback and branch wins redirect
`timescale 1ns/1ns
module ex_unit import cpu_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               issue,
  input  op_class_e          op_class,
  input  alu_op_e            alu_op,
  input  logic               alu_src,         // Second operand from sign_ext
  input  logic [3:0]         shift,
  input  logic [7:0]         load_half_imm,
  input  logic [DATA_W-1:0]  rd_data_1,
  input  logic [DATA_W-1:0]  rd_data_2,
  input  logic [DATA_W-1:0]  sign_ext,
  input  logic [REG_W-1:0]   reg_rd,
  input  br_cond_e           branch_cond,
  input  logic [CALL_W-1:0]  call_target,
  input  logic [DATA_W-1:0]  pc_in,
  input  logic               ls_busy,
  input  logic               cs_busy,
  input  logic               ld_valid,
  input  logic [REG_W-1:0]   ld_rd,
  input  logic [DATA_W-1:0]  ld_data,
  input  logic               ret_valid,
  input  logic [DATA_W-1:0]  ret_pc,
  output logic               issue_ready,
  output logic               ls_start,
  output logic               ls_we,
  output logic [DMEM_AW-1:0] ls_addr,
  output logic [DATA_W-1:0]  ls_wdata,
  output logic [REG_W-1:0]   ls_rd,
  output logic               cs_push,
  output logic               cs_pop,
  output logic [DATA_W-1:0]  cs_wdata,
  output logic [DATA_W-1:0]  call_pc,
  output logic               wb_valid,
  output logic [REG_W-1:0]   wb_rd,
  output logic [DATA_W-1:0]  wb_data,
  output logic               ld_accept,
  output logic               pc_update_done,
  output logic               pc_src,
  output logic [DATA_W-1:0]  pc_update,
  output logic [2:0]         flags
);

  logic              is_mem, is_stk, is_call, take;
  alu_op_e           op_sel;
  br_cond_e          cond_sel;
  logic [2:0]        flags_sel;
  logic [DATA_W-1:0] op_b, alu_res, br_target;
  logic [2:0]        alu_flags;
  logic              br_taken;
  logic              run_q;                      // Low through reset
  logic              alu_v_q, br_v_q, br_taken_q;
  logic [REG_W-1:0]  alu_rd_q;
  logic [DATA_W-1:0] alu_data_q, br_tgt_q;
  logic              hold_q;                     // Stack redirect waiting behind a branch
  logic [DATA_W-1:0] hold_pc_q;

  ////////////////////////////////////////////////////////////////////////////
  // Issue and dispatch
  ////////////////////////////////////////////////////////////////////////////

  assign is_mem  = (op_class == CL_LOAD) || (op_class == CL_STORE);
  assign is_call = (op_class == CL_CALL);
  assign is_stk  = is_call || (op_class == CL_RET);

  assign issue_ready = run_q && !(is_mem && ls_busy) && !(is_stk && (cs_busy || hold_q));
  assign take        = issue && issue_ready;

  assign op_sel    = is_mem ? OP_ADD : alu_op;          // Address = base + offset
  assign op_b      = (alu_src || is_mem) ? sign_ext : rd_data_2;
  assign cond_sel  = is_call ? BR_EQ : branch_cond;     // Forced miss picks call slot
  assign flags_sel = is_call ? 3'b000 : flags;

  alu u_alu (
    .alu_op        (op_sel),
    .a             (rd_data_1),
    .b             (op_b),
    .shift         (shift),
    .load_half_imm (load_half_imm),
    .result        (alu_res),
    .new_flags     (alu_flags)
  );

  pc_update u_pc (
    .pc_in       (pc_in),
    .sign_ext    (sign_ext),
    .flags       (flags_sel),
    .branch_cond (cond_sel),
    .call_target (call_target),
    .taken       (br_taken),
    .target      (br_target)
  );

  assign ls_start = take && is_mem;
  assign ls_we    = (op_class == CL_STORE);
  assign ls_addr  = alu_res[DMEM_AW-1:0];
  assign ls_wdata = rd_data_2;
  assign ls_rd    = reg_rd;
  assign cs_push  = take && is_call;
  assign cs_pop   = take && (op_class == CL_RET);
  assign cs_wdata = pc_in + 1'b1;                       // Return address
  assign call_pc  = br_target;

  ////////////////////////////////////////////////////////////////////////////
  // Result registers and merge
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      run_q   <= 1'b0;
      alu_v_q <= 1'b0;
      br_v_q  <= 1'b0;
      flags   <= '0;
      hold_q  <= 1'b0;
    end else begin
      run_q   <= 1'b1;
      alu_v_q <= take && (op_class == CL_ALU);
      br_v_q  <= take && (op_class == CL_BRANCH);
      if (take && (op_class == CL_ALU))
        flags <= alu_flags;                             // Same edge as the result
      if (br_v_q && ret_valid)
        hold_q <= 1'b1;
      else if (!br_v_q)
        hold_q <= 1'b0;                                 // Sent this cycle
    end
  end

  always_ff @(posedge clk) begin
    alu_rd_q   <= reg_rd;
    alu_data_q <= alu_res;
    br_taken_q <= br_taken;
    br_tgt_q   <= br_target;
    if (br_v_q && ret_valid)
      hold_pc_q <= ret_pc;
  end

  assign wb_valid  = alu_v_q || ld_valid;
  assign wb_rd     = alu_v_q ? alu_rd_q : ld_rd;
  assign wb_data   = alu_v_q ? alu_data_q : ld_data;
  assign ld_accept = ld_valid && !alu_v_q;              // Load waits a cycle on clash

  assign pc_update_done = br_v_q || hold_q || ret_valid;
  assign pc_src         = br_v_q ? br_taken_q : (hold_q || ret_valid);
  assign pc_update      = br_v_q ? br_tgt_q : (hold_q ? hold_pc_q : ret_pc);

endmodule

/* hdl/load_store.sv */
// One-deep load/store unit. Load data stays on ld_data until ld_accept
`timescale 1ns/1ns
module load_store import cpu_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,       // Take one operation
  input  logic               we,          // Store when set
  input  logic [DMEM_AW-1:0] addr,
  input  logic [DATA_W-1:0]  wdata,
  input  logic [REG_W-1:0]   rd,          // Load destination
  input  logic               ld_accept,
  output logic               busy,
  output logic               ld_valid,
  output logic [REG_W-1:0]   ld_rd,
  output logic [DATA_W-1:0]  ld_data,
  output logic               store_done,
  mem_if.requester           mem
);

  typedef enum logic [2:0] {
    LS_IDLE, LS_REQ, LS_RDATA, LS_ST_DONE, LS_LD_DONE
  } ls_state_e;

  ls_state_e          state;
  logic               we_q;
  logic [DMEM_AW-1:0] addr_q;
  logic [DATA_W-1:0]  wdata_q, data_q;
  logic [REG_W-1:0]   rd_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= LS_IDLE;
    end else begin
      case (state)
        LS_IDLE:    if (start) state <= LS_REQ;
        LS_REQ:     if (mem.gnt) state <= we_q ? LS_ST_DONE : LS_RDATA;
        LS_RDATA:   state <= LS_LD_DONE;             // rdata valid now
        LS_ST_DONE: state <= LS_IDLE;
        LS_LD_DONE: if (ld_accept) state <= LS_IDLE;
        default:    state <= LS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == LS_IDLE) && start) begin
      we_q    <= we;
      addr_q  <= addr;
      wdata_q <= wdata;
      rd_q    <= rd;
    end
    if (state == LS_RDATA)
      data_q <= mem.rdata;
  end

  assign mem.req   = (state == LS_REQ);              // Held until granted
  assign mem.we    = we_q;
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata_q;

  assign busy       = (state != LS_IDLE);
  assign store_done = (state == LS_ST_DONE);
  assign ld_valid   = (state == LS_LD_DONE);
  assign ld_rd      = rd_q;
  assign ld_data    = data_q;

endmodule

/* hdl/call_stack.sv */
// Return-address stack in data memory growing down from STACK_TOP. No overflow or underflow check
`timescale 1ns/1ns
module call_stack import cpu_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               push,        // Call
  input  logic               pop,         // Return
  input  logic [DATA_W-1:0]  wdata,       // Return address to save
  input  logic [DATA_W-1:0]  call_pc,     // Call target
  output logic               busy,
  output logic               ret_valid,   // One-cycle redirect strobe
  output logic [DATA_W-1:0]  ret_pc,
  mem_if.requester           mem
);

  typedef enum logic [2:0] {
    CS_IDLE, CS_PUSH, CS_POP, CS_RDATA, CS_DONE
  } cs_state_e;

  cs_state_e          state;
  logic [DMEM_AW-1:0] sp;                 // Next free slot
  logic [DATA_W-1:0]  wdata_q;
  logic [DATA_W-1:0]  tgt_q;              // Call target or popped address

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= CS_IDLE;
      sp    <= STACK_TOP;
    end else begin
      case (state)
        CS_IDLE: begin
          if (push) begin
            state <= CS_PUSH;
          end else if (pop) begin
            sp    <= sp + 1'b1;                      // Step up before the read
            state <= CS_POP;
          end
        end
        CS_PUSH: begin
          if (mem.gnt) begin
            sp    <= sp - 1'b1;                      // Step down after the write
            state <= CS_DONE;
          end
        end
        CS_POP:   if (mem.gnt) state <= CS_RDATA;
        CS_RDATA: state <= CS_DONE;
        CS_DONE:  state <= CS_IDLE;
        default:  state <= CS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == CS_IDLE) && push) begin
      wdata_q <= wdata;
      tgt_q   <= call_pc;
    end
    if (state == CS_RDATA)
      tgt_q <= mem.rdata;
  end

  assign mem.req   = (state == CS_PUSH) || (state == CS_POP);
  assign mem.we    = (state == CS_PUSH);
  assign mem.addr  = sp;
  assign mem.wdata = wdata_q;

  assign busy      = (state != CS_IDLE);
  assign ret_valid = (state == CS_DONE);
  assign ret_pc    = tgt_q;

endmodule

/* hdl/shared_dmem.sv */
// Data memory shared by two requesters. Call stack has fixed priority and the loser keeps waiting
`timescale 1ns/1ns
module shared_dmem import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  mem_if.arbiter    cs,        // Call stack, high priority
  mem_if.arbiter    ls         // Load/store
);

  logic [DATA_W-1:0]  ram [DMEM_DEPTH];
  logic               access;
  logic               we;
  logic [DMEM_AW-1:0] addr;
  logic [DATA_W-1:0]  wdata;
  logic [DATA_W-1:0]  rd_q;              // Read port register
  logic               cs_rd_q, ls_rd_q;  // Owner of rd_q

  ////////////////////////////////////////////////////////////////////////////
  // Arbiter
  ////////////////////////////////////////////////////////////////////////////

  assign cs.gnt = cs.req;
  assign ls.gnt = ls.req && !cs.req;     // At most one grant

  assign access = cs.req || ls.req;
  assign we     = cs.req ? cs.we    : ls.we;
  assign addr   = cs.req ? cs.addr  : ls.addr;
  assign wdata  = cs.req ? cs.wdata : ls.wdata;

  ////////////////////////////////////////////////////////////////////////////
  // Single-port memory
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (access) begin
      if (we)
        ram[addr] <= wdata;
      rd_q <= ram[addr];                 // Old data on a write
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cs_rd_q <= 1'b0;
      ls_rd_q <= 1'b0;
    end else begin
      cs_rd_q <= cs.gnt && !cs.we;
      ls_rd_q <= ls.gnt && !ls.we;
    end
  end

  assign cs.rdata = cs_rd_q ? rd_q : '0;
  assign ls.rdata = ls_rd_q ? rd_q : '0;

endmodule

/* hdl/exec_core.sv */
// Execute back end top. Operands arrive already read and no hazards are checked here
`timescale 1ns/1ns
module exec_core import cpu_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               issue,
  input  op_class_e          op_class,
  input  alu_op_e            alu_op,
  input  logic               alu_src,
  input  logic [3:0]         shift,
  input  logic [7:0]         load_half_imm,
  input  logic [DATA_W-1:0]  rd_data_1,
  input  logic [DATA_W-1:0]  rd_data_2,
  input  logic [DATA_W-1:0]  sign_ext,
  input  logic [REG_W-1:0]   reg_rd,
  input  br_cond_e           branch_cond,
  input  logic [CALL_W-1:0]  call_target,
  input  logic [DATA_W-1:0]  pc_in,
  output logic               issue_ready,
  output logic               wb_valid,
  output logic [REG_W-1:0]   wb_rd,
  output logic [DATA_W-1:0]  wb_data,
  output logic               store_done,
  output logic               pc_update_done,
  output logic               pc_src,
  output logic [DATA_W-1:0]  pc_update,
  output logic [2:0]         flags
);

  logic               ls_start, ls_we, ls_busy, ld_valid, ld_accept;
  logic [DMEM_AW-1:0] ls_addr;
  logic [DATA_W-1:0]  ls_wdata, ld_data;
  logic [REG_W-1:0]   ls_rd, ld_rd;
  logic               cs_push, cs_pop, cs_busy, ret_valid;
  logic [DATA_W-1:0]  cs_wdata, call_pc, ret_pc;

  mem_if ls_mem ();
  mem_if cs_mem ();

  ex_unit u_ex (
    .clk, .rst, .issue, .op_class, .alu_op, .alu_src, .shift, .load_half_imm,
    .rd_data_1, .rd_data_2, .sign_ext, .reg_rd, .branch_cond, .call_target, .pc_in,
    .ls_busy, .cs_busy, .ld_valid, .ld_rd, .ld_data, .ret_valid, .ret_pc,
    .issue_ready, .ls_start, .ls_we, .ls_addr, .ls_wdata, .ls_rd,
    .cs_push, .cs_pop, .cs_wdata, .call_pc,
    .wb_valid, .wb_rd, .wb_data, .ld_accept,
    .pc_update_done, .pc_src, .pc_update, .flags
  );

  load_store u_ls (
    .clk, .rst,
    .start (ls_start),
    .we    (ls_we),
    .addr  (ls_addr),
    .wdata (ls_wdata),
    .rd    (ls_rd),
    .ld_accept, .ld_valid, .ld_rd, .ld_data, .store_done,
    .busy  (ls_busy),
    .mem   (ls_mem)
  );

  call_stack u_cs (
    .clk, .rst,
    .push  (cs_push),
    .pop   (cs_pop),
    .wdata (cs_wdata),
    .call_pc, .ret_valid, .ret_pc,
    .busy  (cs_busy),
    .mem   (cs_mem)
  );

  shared_dmem u_dmem (
    .clk, .rst,
    .cs (cs_mem),
    .ls (ls_mem)
  );

endmodule

/* test/exec_core_asserts.sv */
// Arbiter and load/store checks. Unused ports are tied low where bound
`timescale 1ns/1ns
module exec_core_asserts (
  input logic clk,
  input logic rst,
  input logic req_a,       // Requester A
  input logic gnt_a,
  input logic req_b,       // Requester B
  input logic gnt_b,
  input logic start,       // Load/store accepted
  input logic store_done,
  input logic ld_valid
);

  logic pend;  // Operation started and not yet finished

  always_ff @(posedge clk) begin
    if (rst)
      pend <= 1'b0;
    else
      pend <= start || (pend && !(store_done || ld_valid));
  end

  assert property (@(posedge clk) disable iff (rst) !(gnt_a && gnt_b))
    else $error("Two grants in one cycle");
  assert property (@(posedge clk) disable iff (rst) gnt_a |-> req_a)
    else $error("Grant A without request");
  assert property (@(posedge clk) disable iff (rst) gnt_b |-> req_b)
    else $error("Grant B without request");
  assert property (@(posedge clk) disable iff (rst) (req_a && !gnt_a) |=> req_a)
    else $error("Request A dropped before grant");
  assert property (@(posedge clk) disable iff (rst) (req_b && !gnt_b) |=> req_b)
    else $error("Request B dropped before grant");
  assert property (@(posedge clk) disable iff (rst) $rose(store_done || ld_valid) |-> pend)
    else $error("Load/store completion without a start");

endmodule

bind shared_dmem exec_core_asserts u_arb_chk (
  .clk (clk), .rst (rst),
  .req_a (cs.req), .gnt_a (cs.gnt), .req_b (ls.req), .gnt_b (ls.gnt),
  .start (1'b0), .store_done (1'b0), .ld_valid (1'b0)
);

bind load_store exec_core_asserts u_ls_chk (
  .clk (clk), .rst (rst),
  .req_a (mem.req), .gnt_a (mem.gnt), .req_b (1'b0), .gnt_b (1'b0),
  .start (start), .store_done (store_done), .ld_valid (ld_valid)
);

/* test/exec_core_tb.sv */
// Table-driven testbench for exec_core. The stack wraps from STACK_TOP to 0x00 and row 0 seeds that slot
`timescale 1ns/1ns
module exec_core_tb import cpu_pkg::*; ();

  localparam int MAX_ROWS = 40;

  logic clk, rst, issue, alu_src;
  op_class_e op_class;
  alu_op_e alu_op;
  br_cond_e branch_cond;
  logic [3:0] shift, reg_rd;
  logic [7:0] load_half_imm;
  logic [DATA_W-1:0] rd_data_1, rd_data_2, sign_ext, pc_in, wb_data, pc_update;
  logic [CALL_W-1:0] call_target;
  logic issue_ready, wb_valid, store_done, pc_update_done, pc_src;
  logic [REG_W-1:0] wb_rd;
  logic [2:0] flags;

  // Stimulus table with expected results
  op_class_e t_cls [MAX_ROWS];
  alu_op_e t_op [MAX_ROWS];
  br_cond_e t_cond [MAX_ROWS];
  logic t_src [MAX_ROWS];
  logic [3:0] t_sh [MAX_ROWS];
  logic [7:0] t_imm [MAX_ROWS];
  logic [15:0] t_a [MAX_ROWS], t_b [MAX_ROWS], t_se [MAX_ROWS], t_pc [MAX_ROWS];
  logic [3:0] t_rd [MAX_ROWS];
  logic [11:0] t_ct [MAX_ROWS];
  logic [19:0] t_wb [MAX_ROWS];    // {rd, data}
  logic [16:0] t_redir [MAX_ROWS]; // {pc_src, pc_update}
  logic [2:0] t_fl [MAX_ROWS];
  int nrows;

  // Reference model state
  logic [2:0] m_flags;
  logic [15:0] m_mem [256];
  logic [7:0] m_sp;

  logic [19:0] wbq [$];            // Outstanding writebacks
  logic [16:0] pcq [$];            // Outstanding redirects
  int st_pend, errors, cycles, i;
  bit due_alu, due_br;
  logic [2:0] due_flags;
  logic [31:0] rng;

  exec_core UUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Returns {flags, result}
  function automatic logic [18:0] ref_alu(input alu_op_e op, input logic [15:0] a,
                                          input logic [15:0] b, input logic [3:0] sh,
                                          input logic [7:0] imm);
    logic [15:0] r;
    logic [16:0] s;  // Sign-extended sum or difference
    logic v;
    v = 1'b0;
    case (op)
      OP_ADD: begin
        r = a + b;
        s = {a[15], a} + {b[15], b};
        v = (s[16] != s[15]);
      end
      OP_SUB: begin
        r = a - b;
        s = {a[15], a} - {b[15], b};
        v = (s[16] != s[15]);
      end
      OP_AND: r = a & b;
      OP_OR:  r = a | b;
      OP_XOR: r = a ^ b;
      OP_SLL: r = a << sh;
      OP_SRL: r = a >> sh;
      default: r = {imm, a[7:0]};  // LHI
    endcase
    return {(r == 16'h0), r[15], v, r};
  endfunction

  function automatic logic cond_holds(input br_cond_e c, input logic [2:0] f);
    case (c)
      BR_NE:  return !f[FLAG_Z];
      BR_EQ:  return f[FLAG_Z];
      BR_GT:  return !f[FLAG_Z] && !f[FLAG_N];
      BR_LT:  return f[FLAG_N];
      BR_GE:  return !f[FLAG_N];
      BR_LE:  return f[FLAG_Z] || f[FLAG_N];
      BR_OVF: return f[FLAG_V];
      default: return 1'b1;
    endcase
  endfunction

  task automatic new_row(input op_class_e cls);
    t_cls[nrows] = cls;
    t_op[nrows] = OP_ADD;
    t_cond[nrows] = BR_ALWAYS;
    t_src[nrows] = 1'b0;
    t_sh[nrows] = 4'h0;
    t_imm[nrows] = 8'h00;
    t_a[nrows] = 16'h0;
    t_b[nrows] = 16'h0;
    t_se[nrows] = 16'h0;
    t_pc[nrows] = 16'h0;
    t_rd[nrows] = 4'h0;
    t_ct[nrows] = 12'h0;
    t_fl[nrows] = m_flags;
  endtask

  task automatic alu_row(input alu_op_e op, input logic src, input logic [15:0] a,
                         input logic [15:0] b, input logic [15:0] se, input logic [3:0] sh,
                         input logic [7:0] imm, input logic [3:0] rd);
    logic [18:0] r;
    new_row(CL_ALU);
    t_op[nrows] = op;
    t_src[nrows] = src;
    t_a[nrows] = a;
    t_b[nrows] = b;
    t_se[nrows] = se;
    t_sh[nrows] = sh;
    t_imm[nrows] = imm;
    t_rd[nrows] = rd;
    r = ref_alu(op, a, src ? se : b, sh, imm);
    m_flags = r[18:16];
    t_fl[nrows] = m_flags;
    t_wb[nrows] = {rd, r[15:0]};
    nrows++;
  endtask

  task automatic br_row(input br_cond_e c, input logic [15:0] pc, input logic [15:0] se);
    new_row(CL_BRANCH);
    t_cond[nrows] = c;
    t_pc[nrows] = pc;
    t_se[nrows] = se;
    t_redir[nrows] = {cond_holds(c, m_flags), pc + se};
    nrows++;
  endtask

  task automatic mem_row(input logic st, input logic [15:0] a, input logic [15:0] se,
                         input logic [15:0] b, input logic [3:0] rd);
    logic [15:0] sum;
    new_row(st ? CL_STORE : CL_LOAD);
    t_a[nrows] = a;
    t_se[nrows] = se;
    t_b[nrows] = b;
    t_rd[nrows] = rd;
    sum = a + se;  // Word address is the low byte
    if (st)
      m_mem[sum[7:0]] = b;
    t_wb[nrows] = {rd, m_mem[sum[7:0]]};
    nrows++;
  endtask

  task automatic call_row(input logic [15:0] pc, input logic [11:0] ct);
    new_row(CL_CALL);
    t_pc[nrows] = pc;
    t_ct[nrows] = ct;
    m_mem[m_sp] = pc + 16'd1;
    m_sp = m_sp - 8'd1;
    t_redir[nrows] = {1'b1, 4'h0, ct};
    nrows++;
  endtask

  task automatic ret_row();
    new_row(CL_RET);
    m_sp = m_sp + 8'd1;     // Pre-increment pop
    t_redir[nrows] = {1'b1, m_mem[m_sp]};
    nrows++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Result monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : monitor
    int k;
    bit hit;
    if (rst) begin
      if (wb_valid !== 1'b0 || store_done !== 1'b0 || pc_update_done !== 1'b0 ||
          issue_ready !== 1'b0 || pc_src !== 1'b0 || flags !== 3'b000) begin
        errors++;
        $display("Outputs were not clear while reset was held");
      end
    end else begin
      if (due_alu) begin
        if (!wb_valid) begin
          errors++;
          $display("ALU writeback missing one cycle after issue");
        end
        if (flags !== due_flags) begin
          errors++;
          $display("Error: flags got 0x%h expected 0x%h", flags, due_flags);
        end
        due_alu = 1'b0;
      end
      if (due_br) begin
        if (!pc_update_done) begin
          errors++;
          $display("Branch redirect missing one cycle after issue");
        end
        due_br = 1'b0;
      end
      if (wb_valid) begin
        hit = 1'b0;
        for (k = 0; k < wbq.size(); k++)
          if (!hit && wbq[k] == {wb_rd, wb_data}) begin
            wbq.delete(k);
            hit = 1'b1;
          end
        if (!hit) begin
          errors++;
          $display("Error: wb_rd 0x%h wb_data 0x%h not expected", wb_rd, wb_data);
        end
      end
      if (pc_update_done) begin
        hit = 1'b0;
        for (k = 0; k < pcq.size(); k++)
          if (!hit && pcq[k][16] == pc_src && (!pc_src || pcq[k][15:0] == pc_update)) begin
            pcq.delete(k);
            hit = 1'b1;
          end
        if (!hit) begin
          errors++;
          $display("Error: pc_src 0x%h pc_update 0x%h not expected", pc_src, pc_update);
        end
      end
      if (store_done) begin
        if (st_pend == 0) begin
          errors++;
          $display("store_done came without a pending store");
        end else
          st_pend--;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > 40 * nrows + 100) begin
      $display("Timeout with results still outstanding after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Table build and issue loop
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst = 1'b1;
    issue = 1'b0;
    op_class = CL_ALU;
    alu_op = OP_ADD;
    branch_cond = BR_ALWAYS;
    alu_src = 1'b0;
    shift = 4'h0;
    load_half_imm = 8'h00;
    rd_data_1 = 16'h0;
    rd_data_2 = 16'h0;
    sign_ext = 16'h0;
    pc_in = 16'h0;
    reg_rd = 4'h0;
    call_target = 12'h0;
    errors = 0;
    cycles = 0;
    st_pend = 0;
    nrows = 0;
    m_flags = 3'b000;
    m_sp = STACK_TOP;
    rng = 32'hc1c62ace;

    mem_row(1'b1, 16'h0000, 16'h0000, 16'h0abc, 4'h0);  // Slot read by the first pop
    ret_row();
    alu_row(OP_ADD, 1'b0, 16'h7fff, 16'h0001, 16'h0, 4'h0, 8'h00, 4'h1);  // N and V
    br_row(BR_OVF, 16'h0100, 16'h0010);
    br_row(BR_LT, 16'h0110, 16'hfff0);
    alu_row(OP_SUB, 1'b1, 16'h0005, 16'h1234, 16'h0005, 4'h0, 8'h00, 4'h2); // Z
    br_row(BR_EQ, 16'h0120, 16'h0004);
    br_row(BR_NE, 16'h0124, 16'h0004);
    br_row(BR_LE, 16'h0128, 16'h0008);
    br_row(BR_GT, 16'h012c, 16'h0008);
    alu_row(OP_OR, 1'b0, 16'h0001, 16'h0002, 16'h0, 4'h0, 8'h00, 4'h3);
    br_row(BR_GE, 16'h0130, 16'h0020);
    br_row(BR_ALWAYS, 16'h0134, 16'hff00);
    alu_row(OP_AND, 1'b1, 16'hf0f0, 16'h0, 16'h3c3c, 4'h0, 8'h00, 4'h4);
    alu_row(OP_XOR, 1'b0, 16'haaaa, 16'h5555, 16'h0, 4'h0, 8'h00, 4'h5);
    alu_row(OP_SLL, 1'b0, 16'h8181, 16'h0, 16'h0, 4'h3, 8'h00, 4'h6);
    alu_row(OP_SRL, 1'b0, 16'h8181, 16'h0, 16'h0, 4'h5, 8'h00, 4'h7);
    alu_row(OP_LHI, 1'b1, 16'h12cd, 16'h0, 16'h0, 4'h0, 8'hab, 4'h8);
    for (i = 0; i < 3; i++) begin
      rng = xorshift(rng);
      t_a[0] = rng[15:0];            // Scratch slot until row 0 is rewritten below
      rng = xorshift(rng);
      alu_row(alu_op_e'(rng[2:0]), rng[3], t_a[0], rng[31:16], rng[23:8],
              rng[7:4], rng[15:8], 4'h9 + 4'(i));
    end
    t_a[0] = 16'h0000;
    mem_row(1'b1, 16'h0018, 16'h0008, 16'hbeef, 4'h0);
    mem_row(1'b0, 16'h0010, 16'h0010, 16'h0, 4'hc);
    call_row(16'h0040, 12'h123);
    call_row(16'h0080, 12'h456);
    ret_row();
    ret_row();
    call_row(16'h0090, 12'h200);
    mem_row(1'b0, 16'h0020, 16'h0000, 16'h0, 4'hd);        // Right after a call
    alu_row(OP_ADD, 1'b0, 16'h0200, 16'h0045, 16'h0, 4'h0, 8'h00, 4'hf); // Load in flight
    alu_row(OP_ADD, 1'b0, 16'h0100, 16'h0023, 16'h0, 4'h0, 8'h00, 4'he); // Meets load wb
    ret_row();

    repeat (8) @(posedge clk);
    rst <= 1'b0;
    for (i = 0; i < nrows; i++) begin
      issue <= 1'b1;
      op_class <= t_cls[i];
      alu_op <= t_op[i];
      branch_cond <= t_cond[i];
      alu_src <= t_src[i];
      shift <= t_sh[i];
      load_half_imm <= t_imm[i];
      rd_data_1 <= t_a[i];
      rd_data_2 <= t_b[i];
      sign_ext <= t_se[i];
      pc_in <= t_pc[i];
      reg_rd <= t_rd[i];
      call_target <= t_ct[i];
      @(negedge clk);
      while (!issue_ready) @(negedge clk);  // Hold the row while stalled
      @(posedge clk);
      if (t_cls[i] == CL_ALU || t_cls[i] == CL_LOAD)
        wbq.push_back(t_wb[i]);
      if (t_cls[i] == CL_BRANCH || t_cls[i] == CL_CALL || t_cls[i] == CL_RET)
        pcq.push_back(t_redir[i]);
      if (t_cls[i] == CL_STORE)
        st_pend++;
      due_alu = (t_cls[i] == CL_ALU);
      due_br = (t_cls[i] == CL_BRANCH);
      due_flags = t_fl[i];
    end
    issue <= 1'b0;

    while (wbq.size() != 0 || pcq.size() != 0 || st_pend != 0) @(negedge clk);
    repeat (10) @(negedge clk);           // Catch stray strobes
    $display("Checks done with %0d errors", errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* sim.f */
common/cpu_pkg.sv
common/mem_if.sv
ex_unit/alu.sv
ex_unit/pc_update.sv
ex_unit/ex_unit.sv
hdl/load_store.sv
hdl/call_stack.sv
hdl/shared_dmem.sv
hdl/exec_core.sv
test/exec_core_asserts.sv
test/exec_core_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module exec_core_tb -o exec_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi
out=$(./obj_dir/exec_core_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  exit 1
fi
echo "$out" | grep -qx "TEST OK" || exit 1
exit 0
